// File: Bender.yml
package:
  name: frame_buffer

sources:
  - include_dirs:
      - .
    files:
      - frameBufPkg.sv
      - frameMem.sv
      - hostWriter.sv
      - scanGenerator.sv
      - frameBufferTop.sv
      - target: test
        files:
          - tbFrameBuffer.sv

// File: frameBufPkg.sv
`include "frameBuf_cfg.svh"

package frameBufPkg;

    // host command opcodes
    typedef enum logic [1:0] {
        OpNop      = 2'd0,
        // load address bits 7:0
        OpAddrLow  = 2'd1,
        // load upper address bits from the low nibble of data
        OpAddrHigh = 2'd2,
        // write data at the address, then post-increment
        OpWrite    = 2'd3
    } hostOpE;

    // single-cycle host command
    typedef struct packed {
        hostOpE                 opcode;
        logic [`FB_DATA_W-1:0]  data;
    } hostCmdT;

    // scan FSM states
    typedef enum logic {
        ScanIdle   = 1'b0,
        ScanActive = 1'b1
    } scanStateE;

    // RGB565 color, red sits in the top bits of the pixel word
    typedef struct packed {
        logic [4:0] red;
        logic [5:0] green;
        logic [4:0] blue;
    } rgb565T;

    // decoded pixel with its position on the panel
    typedef struct packed {
        logic [`FB_ROW_W-1:0]   row;
        logic [`FB_COL_W-1:0]   col;
        rgb565T                 color;
    } pixelT;

endpackage

// File: frameBuf_cfg.svh
`ifndef FRAMEBUF_CFG_SVH
`define FRAMEBUF_CFG_SVH

// panel geometry
`define FB_WIDTH 64
`define FB_HEIGHT 32
`define FB_BYTES_PER_PIXEL 2

// memory size in pixels and in bytes
`define FB_NUM_PIXELS (`FB_WIDTH * `FB_HEIGHT)
`define FB_NUM_BYTES (`FB_NUM_PIXELS * `FB_BYTES_PER_PIXEL)

// byte address for host writes, 12 bits for the 64x32 panel
`define FB_BYTE_ADDR_W ($clog2(`FB_NUM_BYTES))

// pixel address for 16-bit reads, one bit narrower
`define FB_PIXEL_ADDR_W ($clog2(`FB_NUM_PIXELS))

// coordinate widths
// the pixel index splits as {row, col}
`define FB_COL_W ($clog2(`FB_WIDTH))
`define FB_ROW_W ($clog2(`FB_HEIGHT))

// host data byte
`define FB_DATA_W 8

// last byte touched by the power-on clear
`define FB_LAST_BYTE (`FB_NUM_BYTES - 1)

`endif

// File: frameBufferTop.sv
`timescale 1ns/1ps
`include "frameBuf_cfg.svh"

module frameBufferTop import frameBufPkg::*; (
    input  logic    ClockA,
    input  logic    rstN,
    input  logic    cmdValid,
    input  hostCmdT cmd,
    output logic    ready,
    input  logic    scanEn,
    output logic    pixelValid,
    output pixelT   pixel,
    output logic    frameStart
);

    // host to memory
    logic                        wrEn;
    logic [`FB_BYTE_ADDR_W-1:0]  wrAddr;
    logic [`FB_DATA_W-1:0]       wrData;

    // scan read path
    logic                        rdEn;
    logic [`FB_PIXEL_ADDR_W-1:0] rdPixelAddr;
    rgb565T                      rdWord;

    logic                        clearBusy;

    hostWriter uHostWriter (
        .ClockA   (ClockA),
        .rstN     (rstN),
        .cmdValid (cmdValid),
        .cmd      (cmd),
        .wrEn     (wrEn),
        .wrAddr   (wrAddr),
        .wrData   (wrData)
    );

    frameMem uFrameMem (
        .ClockA      (ClockA),
        .rstN        (rstN),
        .wrEn        (wrEn),
        .wrAddr      (wrAddr),
        .wrData      (wrData),
        .rdEn        (rdEn),
        .rdPixelAddr (rdPixelAddr),
        .rdWord      (rdWord),
        .clearBusy   (clearBusy)
    );

    scanGenerator uScanGenerator (
        .ClockA      (ClockA),
        .rstN        (rstN),
        .scanEn      (scanEn),
        .rdEn        (rdEn),
        .rdPixelAddr (rdPixelAddr),
        .rdWord      (rdWord),
        .pixelValid  (pixelValid),
        .pixel       (pixel),
        .frameStart  (frameStart)
    );

    // host writes land only once the clear sweep is done
    assign ready = !clearBusy;

endmodule

// File: frameMem.sv
`timescale 1ns/1ps
`include "frameBuf_cfg.svh"

module frameMem import frameBufPkg::*; (
    input  logic                        ClockA,
    input  logic                        rstN,
    input  logic                        wrEn,
    input  logic [`FB_BYTE_ADDR_W-1:0]  wrAddr,
    input  logic [`FB_DATA_W-1:0]       wrData,
    input  logic                        rdEn,
    input  logic [`FB_PIXEL_ADDR_W-1:0] rdPixelAddr,
    output rgb565T                      rdWord,
    output logic                        clearBusy
);

    // byte-wide storage, two bytes per pixel
    logic [`FB_DATA_W-1:0] mem [0:`FB_NUM_BYTES-1];

    // high during reset and for the first cycle after it
    logic clearStart;
    logic [`FB_BYTE_ADDR_W-1:0] clearAddr;

    // clear sweep control
    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            clearStart <= 1'b1;
            clearBusy  <= 1'b0;
            clearAddr  <= '0;
        end else begin
            clearStart <= 1'b0;
            if (clearStart) begin
                clearBusy <= 1'b1;
            end else if (clearBusy && clearAddr == `FB_BYTE_ADDR_W'(`FB_LAST_BYTE)) begin
                // last byte zeroed at this edge
                clearBusy <= 1'b0;
            end
            if (clearBusy) begin
                clearAddr <= clearAddr + 1'b1;
            end
        end
    end

    // single write port, the sweep wins over the host
    always_ff @(posedge ClockA) begin
        if (clearBusy) begin
            mem[clearAddr] <= '0;
        end else if (wrEn && !clearStart) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered pixel read
    // odd byte is the high half, even byte the low half
    // a write to the same byte in this cycle is not seen yet
    always_ff @(posedge ClockA) begin
        if (rdEn) begin
            rdWord <= rgb565T'({mem[{rdPixelAddr, 1'b1}], mem[{rdPixelAddr, 1'b0}]});
        end
    end

endmodule

// File: hostWriter.sv
`timescale 1ns/1ps
`include "frameBuf_cfg.svh"

module hostWriter import frameBufPkg::*; (
    input  logic                        ClockA,
    input  logic                        rstN,
    input  logic                        cmdValid,
    input  hostCmdT                     cmd,
    output logic                        wrEn,
    output logic [`FB_BYTE_ADDR_W-1:0]  wrAddr,
    output logic [`FB_DATA_W-1:0]       wrData
);

    // byte address for the next write
    logic [`FB_BYTE_ADDR_W-1:0] addrReg;

    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            addrReg <= '0;
        end else if (cmdValid) begin
            case (cmd.opcode)
                OpAddrLow: begin
                    addrReg[7:0] <= cmd.data;
                end
                OpAddrHigh: begin
                    // only the low nibble reaches the address
                    addrReg[`FB_BYTE_ADDR_W-1:8] <= cmd.data[`FB_BYTE_ADDR_W-9:0];
                end
                OpWrite: begin
                    // wraps from the last byte back to 0
                    addrReg <= addrReg + 1'b1;
                end
                default: begin
                    addrReg <= addrReg;
                end
            endcase
        end
    end

    // write strobe in the same cycle as the command
    assign wrEn = cmdValid && (cmd.opcode == OpWrite);

    // address before the increment
    assign wrAddr = addrReg;
    assign wrData = cmd.data;

endmodule

// File: scanGenerator.sv
`timescale 1ns/1ps
`include "frameBuf_cfg.svh"

module scanGenerator import frameBufPkg::*; (
    input  logic                        ClockA,
    input  logic                        rstN,
    input  logic                        scanEn,
    output logic                        rdEn,
    output logic [`FB_PIXEL_ADDR_W-1:0] rdPixelAddr,
    input  rgb565T                      rdWord,
    output logic                        pixelValid,
    output pixelT                       pixel,
    output logic                        frameStart
);

    scanStateE state;

    // next pixel to request
    logic [`FB_PIXEL_ADDR_W-1:0] pixIdx;

    // index of the read now returning from memory
    logic [`FB_PIXEL_ADDR_W-1:0] issuedIdx;

    // FSM: idle until enabled, back to idle when scanEn drops
    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            state <= ScanIdle;
        end else begin
            case (state)
                ScanIdle: begin
                    if (scanEn) begin
                        state <= ScanActive;
                    end
                end
                ScanActive: begin
                    if (!scanEn) begin
                        state <= ScanIdle;
                    end
                end
                default: begin
                    state <= ScanIdle;
                end
            endcase
        end
    end

    // issue stops in the same cycle scanEn goes low
    assign rdEn = (state == ScanActive) && scanEn;
    assign rdPixelAddr = pixIdx;

    // index counter, wraps after the last pixel
    always_ff @(posedge ClockA) begin
        if (!rstN) begin
            pixIdx     <= '0;
            pixelValid <= 1'b0;
        end else begin
            pixelValid <= rdEn;
            if (rdEn) begin
                pixIdx <= pixIdx + 1'b1;
            end
        end
    end

    // line up the index with the memory latency
    always_ff @(posedge ClockA) begin
        if (rdEn) begin
            issuedIdx <= pixIdx;
        end
    end

    // row-major split of the index
    assign pixel.row   = issuedIdx[`FB_PIXEL_ADDR_W-1:`FB_COL_W];
    assign pixel.col   = issuedIdx[`FB_COL_W-1:0];
    assign pixel.color = rdWord;

    assign frameStart = pixelValid && (issuedIdx == '0);

endmodule

// File: sources.f
+incdir+.
frameBufPkg.sv
frameMem.sv
hostWriter.sv
scanGenerator.sv
frameBufferTop.sv
tbFrameBuffer.sv

// File: tbFrameBuffer.sv
`timescale 1ns/1ps
`include "frameBuf_cfg.svh"

module tbFrameBuffer import frameBufPkg::*; ();

    // reset plus clear ~4100, three frames ~2100 each, a few hundred commands,
    // then close to twice that as margin
    localparam int TimeoutCycles = 20000;
    localparam int RandomCmds    = 300;

    logic    ClockA;
    logic    rstN;
    logic    cmdValid;
    hostCmdT cmd;
    logic    ready;
    logic    scanEn;
    logic    pixelValid;
    pixelT   pixel;
    logic    frameStart;

    // reference model of the frame memory and the host address register
    logic [`FB_DATA_W-1:0]       refMem [0:`FB_NUM_BYTES-1];
    logic [`FB_BYTE_ADDR_W-1:0]  refAddr;
    rgb565T                      expColor;
    logic [`FB_PIXEL_ADDR_W-1:0] expIdx;
    int                          pixelsSeen;
    int                          relEdges;
    int                          cycleCount;

    frameBufferTop u_dut (
        .ClockA     (ClockA),
        .rstN       (rstN),
        .cmdValid   (cmdValid),
        .cmd        (cmd),
        .ready      (ready),
        .scanEn     (scanEn),
        .pixelValid (pixelValid),
        .pixel      (pixel),
        .frameStart (frameStart)
    );

    always #2 ClockA = ~ClockA;

    task automatic reportMismatch(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("TESTS FAILED");
        $fatal(1, "stopping on first error");
    endtask

    // red is the top five bits of the odd byte, blue the low five of the even byte
    function automatic rgb565T expectedColor(input logic [`FB_PIXEL_ADDR_W-1:0] idx);
        logic [`FB_DATA_W-1:0] hiByte;
        logic [`FB_DATA_W-1:0] loByte;
        rgb565T                color;
        hiByte      = refMem[{idx, 1'b1}];
        loByte      = refMem[{idx, 1'b0}];
        color.red   = hiByte[7:3];
        color.green = {hiByte[2:0], loByte[7:5]};
        color.blue  = loByte[4:0];
        return color;
    endfunction

    // one command per call, model follows the host opcode rules
    task automatic sendCmd(input hostOpE op, input logic [`FB_DATA_W-1:0] data);
        cmdValid   = 1'b1;
        cmd.opcode = op;
        cmd.data   = data;
        case (op)
            OpAddrLow: begin
                refAddr[7:0] = data;
            end
            OpAddrHigh: begin
                refAddr[`FB_BYTE_ADDR_W-1:8] = data[`FB_BYTE_ADDR_W-9:0];
            end
            OpWrite: begin
                if (ready) begin
                    refMem[refAddr] = data;
                end
                refAddr = refAddr + 1'b1;
            end
            default: begin
                // nop leaves everything alone
            end
        endcase
        @(negedge ClockA);
        cmdValid = 1'b0;
    endtask

    // collect at least count pixels, optionally with short scanEn gaps
    task automatic scanPixels(input int count, input bit withGaps);
        int target;
        int gapLeft;
        target  = pixelsSeen + count;
        gapLeft = 0;
        while (pixelsSeen < target) begin
            if (withGaps && gapLeft == 0 && $urandom_range(0, 7) == 0) begin
                gapLeft = $urandom_range(1, 4);
            end
            if (gapLeft > 0) begin
                scanEn = 1'b0;
                gapLeft--;
            end else begin
                scanEn = 1'b1;
            end
            @(negedge ClockA);
        end
        scanEn = 1'b0;
        // let the last read drain
        repeat (3) @(negedge ClockA);
    endtask

    always @(posedge ClockA) begin
        cycleCount <= cycleCount + 1;
        if (rstN) begin
            relEdges <= relEdges + 1;
        end
        if (rstN && pixelValid) begin
            pixelsSeen <= pixelsSeen + 1;
            expIdx     <= expIdx + 1'b1;
        end
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    // expIdx already names the pixel checked at the next edge
    always @(negedge ClockA) begin
        expColor = expectedColor(expIdx);
    end

    readyTiming: assert property (@(posedge ClockA)
        rstN |-> ready == (relEdges == 0 || relEdges > `FB_NUM_BYTES))
        else reportMismatch($sformatf("ready is %b, %0d cycles after reset release",
                                      $sampled(ready), $sampled(relEdges)));

    scanOrder: assert property (@(posedge ClockA)
        rstN && pixelValid |-> {pixel.row, pixel.col} == expIdx)
        else reportMismatch($sformatf("pixel at row %0d col %0d, expected index %0d",
                                      $sampled(pixel.row), $sampled(pixel.col),
                                      $sampled(expIdx)));

    frameStartMatch: assert property (@(posedge ClockA)
        rstN |-> frameStart == (pixelValid && pixel.row == '0 && pixel.col == '0))
        else reportMismatch($sformatf("frameStart %b with valid %b at row %0d col %0d",
                                      $sampled(frameStart), $sampled(pixelValid),
                                      $sampled(pixel.row), $sampled(pixel.col)));

    redMatch: assert property (@(posedge ClockA)
        rstN && pixelValid |-> pixel.color.red == expColor.red)
        else reportMismatch($sformatf("red %h expected %h at row %0d col %0d",
                                      $sampled(pixel.color.red), $sampled(expColor.red),
                                      $sampled(pixel.row), $sampled(pixel.col)));

    greenMatch: assert property (@(posedge ClockA)
        rstN && pixelValid |-> pixel.color.green == expColor.green)
        else reportMismatch($sformatf("green %h expected %h at row %0d col %0d",
                                      $sampled(pixel.color.green), $sampled(expColor.green),
                                      $sampled(pixel.row), $sampled(pixel.col)));

    blueMatch: assert property (@(posedge ClockA)
        rstN && pixelValid |-> pixel.color.blue == expColor.blue)
        else reportMismatch($sformatf("blue %h expected %h at row %0d col %0d",
                                      $sampled(pixel.color.blue), $sampled(expColor.blue),
                                      $sampled(pixel.row), $sampled(pixel.col)));

    // at most one pixel in flight once scanEn is low
    drainLimit: assert property (@(posedge ClockA)
        rstN && pixelValid |-> $past(scanEn))
        else reportMismatch("pixelValid more than one cycle after scanEn went low");

    initial begin
        int unsigned seedSink;
        int pick;
        seedSink   = $urandom(32'hfa69_5c10);
        ClockA     = 1'b0;
        rstN       = 1'b0;
        cmdValid   = 1'b0;
        cmd        = '0;
        scanEn     = 1'b0;
        refAddr    = '0;
        expIdx     = '0;
        pixelsSeen = 0;
        relEdges   = 0;
        cycleCount = 0;
        for (int i = 0; i < `FB_NUM_BYTES; i++) begin
            refMem[i] = '0;
        end
        repeat (5) @(negedge ClockA);
        rstN = 1'b1;
        @(negedge ClockA);

        // writes into bytes the sweep has already zeroed must be dropped
        repeat (16) @(negedge ClockA);
        repeat (4) begin
            sendCmd(OpWrite, 8'($urandom_range(1, 255)));
        end
        while (!ready) begin
            @(negedge ClockA);
        end

        // cleared frame reads back as zero
        scanPixels(`FB_NUM_PIXELS, 1'b0);

        // random host traffic, idle cycles carry a write opcode without cmdValid
        repeat (RandomCmds) begin
            pick = $urandom_range(0, 9);
            if (pick == 0) begin
                sendCmd(OpAddrHigh, 8'($urandom_range(0, 255)));
            end else if (pick == 1) begin
                sendCmd(OpAddrLow, 8'($urandom_range(0, 255)));
            end else if (pick == 2) begin
                sendCmd(OpNop, 8'($urandom_range(0, 255)));
            end else if (pick == 3) begin
                cmd.opcode = OpWrite;
                cmd.data   = 8'($urandom_range(0, 255));
                @(negedge ClockA);
            end else begin
                sendCmd(OpWrite, 8'($urandom_range(0, 255)));
            end
        end
        scanPixels(`FB_NUM_PIXELS, 1'b0);

        // write run across the top of the byte space
        sendCmd(OpAddrHigh, 8'h0f);
        sendCmd(OpAddrLow, 8'hfe);
        sendCmd(OpWrite, 8'ha5);
        sendCmd(OpWrite, 8'h3c);
        sendCmd(OpWrite, 8'h96);
        sendCmd(OpWrite, 8'h5a);

        // gap scan also covers the wrapped pixels 2047 and 0
        scanPixels(`FB_NUM_PIXELS, 1'b1);

        $display("TESTS PASSED");
        $finish;
    end

endmodule
